// File: vlog.f
src/snoop_pkg.sv
src/trace_engine.sv
src/buffer_arbiter.sv
src/trace_sram.sv
src/readout_port.sv
src/trace_snooper_top.sv
bench/snoop_assertions.sv
bench/tb_trace_snooper.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := tb_trace_snooper
FILELIST := vlog.f
OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^TESTS PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_trace_snooper.sv
/*
 * Trace snooper testbench
 * Random trace records against a byte-level reference model of the buffer,
 * pointer checks after every capture and read-back through the host port
 */
`timescale 1ns/1ps

module tb_trace_snooper import snoop_pkg::*; ();

   localparam logic [31:0] SEED            = 32'd40143;
   localparam int          N_REC           = 8;
   localparam int          N_OPC           = 16;
   localparam int          ADDR_WRAP_RECS  = 54;
   localparam int          INSTR_WRAP_RECS = 260;
   localparam int          RD_TIMEOUT      = 32;
   // Traces and reads of all phases plus the drop, contention and reset steps
   localparam int N_OPS = N_REC * (REC_WORDS + 1) + 2 * N_OPC + ADDR_WRAP_RECS + 20
                          + INSTR_WRAP_RECS + 5 + 40;

   logic              clk;
   logic              rst_n;
   logic              trace_valid;
   logic [DATA_W-1:0] pc_src_l, pc_src_h, pc_dst_l, pc_dst_h, metadata, opcode;
   logic              snoop_en;
   mode_e             mode;
   logic              cnt_rst;
   logic              rd_req;
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_valid;
   logic [DATA_W-1:0] rd_data;
   logic [ADDR_W-1:0] cnt, first_valid, last_valid;
   logic [DATA_W-1:0] drop_cnt;

   // Reference model
   logic [7:0]        ref_mem [TRACE_BUF_BYTES];
   logic [ADDR_W-1:0] ref_cnt, ref_first, ref_last;
   logic [DATA_W-1:0] ref_drop;
   logic              ref_wrapped;
   int                busy_end;
   int                cyc = 0;
   logic [31:0]       rng;
   logic [ADDR_W-1:0] rd_pending [$];
   logic [ADDR_W-1:0] rec_start;

   trace_snooper_top u_dut (
      .clk_i         (clk),
      .rst_ni        (rst_n),
      .trace_valid_i (trace_valid),
      .pc_src_l_i    (pc_src_l),
      .pc_src_h_i    (pc_src_h),
      .pc_dst_l_i    (pc_dst_l),
      .pc_dst_h_i    (pc_dst_h),
      .metadata_i    (metadata),
      .opcode_i      (opcode),
      .snoop_en_i    (snoop_en),
      .mode_i        (mode),
      .cnt_rst_i     (cnt_rst),
      .rd_req_i      (rd_req),
      .rd_addr_i     (rd_addr),
      .rd_valid_o    (rd_valid),
      .rd_data_o     (rd_data),
      .cnt_o         (cnt),
      .first_valid_o (first_valid),
      .last_valid_o  (last_valid),
      .drop_cnt_o    (drop_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Expected buffer word assembled little-endian from the model bytes
   function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] w;
      for (int b = 0; b < 4; b++) begin
         w[8*b +: 8] = ref_mem[addr + ADDR_W'(b)];
      end
      return w;
   endfunction

   task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      for (int b = 0; b < 4; b++) begin
         ref_mem[addr + ADDR_W'(b)] = data[8*b +: 8];
      end
   endtask

   task automatic draw(output logic [DATA_W-1:0] value);
      rng = xorshift32(rng);
      value = rng;
   endtask

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         stop_with_error($sformatf("FAIL at %0t: %s is %h, expected %h",
                                   $time, name, got, exp));
      end
   endtask

   task automatic check_pointers();
      check_value("cnt_o", 32'(cnt), 32'(ref_cnt));
      check_value("first_valid_o", 32'(first_valid), 32'(ref_first));
      check_value("last_valid_o", 32'(last_valid), 32'(ref_last));
      check_value("drop_cnt_o", drop_cnt, ref_drop);
   endtask

   // Pointer step with wrap past the mode limit and the oldest record once wrapped
   task automatic advance_pointers();
      int step;
      int lim;
      int next;
      step = (mode == MODE_INSTR) ? 4 : 20;
      lim  = (mode == MODE_INSTR) ? int'(INSTR_MODE_MAX) : int'(ADDR_MODE_MAX);
      next = int'(ref_cnt) + step;
      ref_last = ref_cnt;
      if (next > lim) begin
         ref_cnt     = '0;
         ref_wrapped = 1'b1;
      end else begin
         ref_cnt = ADDR_W'(next);
      end
      if (ref_wrapped) begin
         ref_first = ref_cnt;
      end
   endtask

   // One strobe with random fields that the model applies at the coming edge
   task automatic send_trace();
      int                edge_no;
      logic [DATA_W-1:0] words [REC_WORDS];
      edge_no = cyc + 1;
      draw(pc_src_l);
      draw(pc_src_h);
      draw(pc_dst_l);
      draw(pc_dst_h);
      draw(metadata);
      draw(opcode);
      trace_valid = 1'b1;
      words = '{pc_src_l, pc_src_h, pc_dst_l, pc_dst_h, metadata};
      if (snoop_en && edge_no <= busy_end) begin
         ref_drop++;
      end else if (snoop_en && mode == MODE_INSTR) begin
         busy_end = edge_no + 1;
         store_word(ref_cnt, opcode);
         advance_pointers();
      end else if (snoop_en) begin
         busy_end = edge_no + REC_WORDS;
         for (int k = 0; k < REC_WORDS; k++) begin
            store_word(ref_cnt + ADDR_W'(4 * k), words[k]);
         end
         advance_pointers();
      end
      @(negedge clk);
      trace_valid = 1'b0;
      check_pointers();
   endtask

   task automatic read_word(input logic [ADDR_W-1:0] addr);
      int waited;
      waited = 0;
      rd_req = 1'b1;
      rd_addr = addr;
      rd_pending.push_back(addr);
      @(negedge clk);
      rd_req = 1'b0;
      while (!rd_valid) begin
         if (waited == RD_TIMEOUT) begin
            stop_with_error($sformatf("Read of address %0d never returned data", addr));
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic counter_reset(input mode_e new_mode);
      cnt_rst = 1'b1;
      mode = new_mode;
      ref_cnt = '0;
      ref_first = '0;
      ref_last = '0;
      ref_drop = '0;
      ref_wrapped = 1'b0;
      busy_end = 0;
      @(negedge clk);
      cnt_rst = 1'b0;
      check_pointers();
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Compare every returned word with the model at the requested address
   always @(negedge clk) begin
      if (rd_valid === 1'b1) begin
         if (rd_pending.size() == 0) begin
            stop_with_error("Read data returned with no read outstanding");
         end else begin
            check_value("rd_data_o", rd_data, ref_word(rd_pending.pop_front()));
         end
      end
   end

   initial begin
      repeat (N_OPS * 20) @(posedge clk);
      stop_with_error("Watchdog expired before the tests finished");
   end

   initial begin
      rng = SEED;
      rst_n = 1'b0;
      trace_valid = 1'b0;
      pc_src_l = '0;
      pc_src_h = '0;
      pc_dst_l = '0;
      pc_dst_h = '0;
      metadata = '0;
      opcode = '0;
      snoop_en = 1'b1;
      mode = MODE_ADDRESS;
      cnt_rst = 1'b0;
      rd_req = 1'b0;
      rd_addr = '0;
      ref_cnt = '0;
      ref_first = '0;
      ref_last = '0;
      ref_drop = '0;
      ref_wrapped = 1'b0;
      busy_end = 0;
      rec_start = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // Address mode round trip
      for (int r = 0; r < N_REC; r++) begin
         send_trace();
         idle(5);
      end
      for (int a = 0; a < N_REC * 20; a += 4) begin
         read_word(ADDR_W'(a));
      end

      // Instruction mode
      counter_reset(MODE_INSTR);
      for (int r = 0; r < N_OPC; r++) begin
         send_trace();
         idle(1);
      end
      for (int a = 0; a < N_OPC * 4; a += 4) begin
         read_word(ADDR_W'(a));
      end

      // Wrap in address mode
      // The 51st record fills the last slot
      counter_reset(MODE_ADDRESS);
      for (int r = 0; r < ADDR_WRAP_RECS; r++) begin
         send_trace();
         if (r == 50) begin
            check_value("cnt_o", 32'(cnt), 32'd0);
         end
         idle(5);
      end
      for (int a = 0; a < 80; a += 4) begin
         read_word(ADDR_W'(a));
      end

      // Wrap in instruction mode
      counter_reset(MODE_INSTR);
      for (int r = 0; r < INSTR_WRAP_RECS; r++) begin
         send_trace();
         idle(1);
      end
      for (int a = 0; a < 20; a += 4) begin
         read_word(ADDR_W'(a));
      end

      // Back-to-back strobes and strobes while disabled
      counter_reset(MODE_ADDRESS);
      repeat (4) send_trace();
      idle(5);
      snoop_en = 1'b0;
      repeat (2) send_trace();
      snoop_en = 1'b1;
      for (int a = 0; a < 20; a += 4) begin
         read_word(ADDR_W'(a));
      end

      // Reads of the record that the engine is still writing
      for (int i = 0; i < 4; i++) begin
         rec_start = ref_cnt;
         fork
            send_trace();
            begin
               @(negedge clk);
               read_word(rec_start + ADDR_W'(4 * i));
            end
         join
      end

      // Drop counter is nonzero here
      counter_reset(MODE_ADDRESS);
      idle(2);

      if (u_dut.u_assert.assert_fails == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         stop_with_error("Concurrent assertions failed during the run");
      end
   end

endmodule

// File: bench/snoop_assertions.sv
/*
 * Trace snooper protocol checks
 * Arbiter exclusivity, engine priority, read valid width and pointer range
 */
`timescale 1ns/1ps

module snoop_assertions import snoop_pkg::*; (
   input logic              clk_i,
   input logic              rst_ni,
   input logic              eng_req_i,
   input logic              eng_gnt_i,
   input logic              rdp_gnt_i,
   input logic              rd_valid_i,
   input logic              cnt_rst_i,
   input mode_e             mode_i,
   input logic [ADDR_W-1:0] cnt_i
);

   int unsigned assert_fails = 0;
   logic [ADDR_W-1:0] limit;

   assign limit = (mode_i == MODE_INSTR) ? INSTR_MODE_MAX : ADDR_MODE_MAX;

   a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(eng_gnt_i && rdp_gnt_i))
      else begin
         $error("Engine and readout granted in the same cycle");
         assert_fails++;
      end

   a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rd_valid_i |=> !rd_valid_i)
      else begin
         $error("Read valid held for more than one cycle");
         assert_fails++;
      end

   a_eng_priority: assert property (@(posedge clk_i) disable iff (!rst_ni)
      eng_req_i |-> eng_gnt_i)
      else begin
         $error("Engine request not granted");
         assert_fails++;
      end

   // A mode change always comes with a counter reset
   a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !cnt_rst_i |-> cnt_i <= limit)
      else begin
         $error("Write pointer above the mode limit");
         assert_fails++;
      end

endmodule

bind trace_snooper_top snoop_assertions u_assert (
   .clk_i      (clk_i),
   .rst_ni     (rst_ni),
   .eng_req_i  (eng_req),
   .eng_gnt_i  (eng_gnt),
   .rdp_gnt_i  (rdp_gnt),
   .rd_valid_i (rd_valid_o),
   .cnt_rst_i  (cnt_rst_i),
   .mode_i     (mode_i),
   .cnt_i      (cnt_o)
);

// File: src/trace_snooper_top.sv
/*
 * Trace snooper top level
 * Engine and host readout sharing one trace buffer SRAM through an arbiter
 */
`timescale 1ns/1ps

module trace_snooper_top import snoop_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              trace_valid_i,
   input  logic [DATA_W-1:0] pc_src_l_i,
   input  logic [DATA_W-1:0] pc_src_h_i,
   input  logic [DATA_W-1:0] pc_dst_l_i,
   input  logic [DATA_W-1:0] pc_dst_h_i,
   input  logic [DATA_W-1:0] metadata_i,
   input  logic [DATA_W-1:0] opcode_i,
   input  logic              snoop_en_i,
   input  mode_e             mode_i,
   input  logic              cnt_rst_i,
   input  logic              rd_req_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output logic              rd_valid_o,
   output logic [DATA_W-1:0] rd_data_o,
   output logic [ADDR_W-1:0] cnt_o,
   output logic [ADDR_W-1:0] first_valid_o,
   output logic [ADDR_W-1:0] last_valid_o,
   output logic [DATA_W-1:0] drop_cnt_o
);

   logic               eng_req;
   logic [ADDR_W-1:0]  eng_addr;
   logic [DATA_W-1:0]  eng_wdata;
   logic               eng_gnt;
   logic               rdp_req;
   logic [ADDR_W-1:0]  rdp_addr;
   logic               rdp_gnt;
   logic               mem_en;
   logic               mem_we;
   logic [WORD_AW-1:0] mem_addr;
   logic [DATA_W-1:0]  mem_wdata;
   logic [DATA_W-1:0]  mem_rdata;

   trace_engine u_engine (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .trace_valid_i (trace_valid_i),
      .snoop_en_i    (snoop_en_i),
      .mode_i        (mode_i),
      .cnt_rst_i     (cnt_rst_i),
      .pc_src_l_i    (pc_src_l_i),
      .pc_src_h_i    (pc_src_h_i),
      .pc_dst_l_i    (pc_dst_l_i),
      .pc_dst_h_i    (pc_dst_h_i),
      .metadata_i    (metadata_i),
      .opcode_i      (opcode_i),
      .gnt_i         (eng_gnt),
      .req_o         (eng_req),
      .addr_o        (eng_addr),
      .wdata_o       (eng_wdata),
      .cnt_o         (cnt_o),
      .first_valid_o (first_valid_o),
      .last_valid_o  (last_valid_o),
      .drop_cnt_o    (drop_cnt_o)
   );

   readout_port u_readout (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .rd_req_i   (rd_req_i),
      .rd_addr_i  (rd_addr_i),
      .gnt_i      (rdp_gnt),
      .rdata_i    (mem_rdata),
      .req_o      (rdp_req),
      .addr_o     (rdp_addr),
      .rd_valid_o (rd_valid_o),
      .rd_data_o  (rd_data_o)
   );

   buffer_arbiter u_arbiter (
      .eng_req_i   (eng_req),
      .eng_addr_i  (eng_addr),
      .eng_wdata_i (eng_wdata),
      .rdp_req_i   (rdp_req),
      .rdp_addr_i  (rdp_addr),
      .eng_gnt_o   (eng_gnt),
      .rdp_gnt_o   (rdp_gnt),
      .mem_en_o    (mem_en),
      .mem_we_o    (mem_we),
      .mem_addr_o  (mem_addr),
      .mem_wdata_o (mem_wdata)
   );

   trace_sram u_sram (
      .clk_i   (clk_i),
      .en_i    (mem_en),
      .we_i    (mem_we),
      .addr_i  (mem_addr),
      .wdata_i (mem_wdata),
      .rdata_o (mem_rdata)
   );

endmodule

// File: src/readout_port.sv
/*
 * Host readout port
 * Holds one read until the arbiter grants it, then returns the word with a
 * single-cycle valid
 */
`timescale 1ns/1ps

module readout_port import snoop_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              rd_req_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   input  logic              gnt_i,
   input  logic [DATA_W-1:0] rdata_i,
   output logic              req_o,
   output logic [ADDR_W-1:0] addr_o,
   output logic              rd_valid_o,
   output logic [DATA_W-1:0] rd_data_o
);

   logic pending_q;
   logic ret_q;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         pending_q  <= 1'b0;
         ret_q      <= 1'b0;
         rd_valid_o <= 1'b0;
      end else begin
         // New strobes are ignored while one read is waiting
         if (!pending_q && rd_req_i) begin
            pending_q <= 1'b1;
         end else if (pending_q && gnt_i) begin
            pending_q <= 1'b0;
         end
         // SRAM data is ready the cycle after the grant
         ret_q      <= pending_q & gnt_i;
         rd_valid_o <= ret_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!pending_q && rd_req_i) begin
         addr_o <= rd_addr_i;
      end
      if (ret_q) begin
         rd_data_o <= rdata_i;
      end
   end

   assign req_o = pending_q;

endmodule

// File: src/trace_sram.sv
/*
 * Trace buffer memory
 * Single-port word SRAM, full-word writes and registered read data
 */
`timescale 1ns/1ps

module trace_sram import snoop_pkg::*; (
   input  logic               clk_i,
   input  logic               en_i,
   input  logic               we_i,
   input  logic [WORD_AW-1:0] addr_i,
   input  logic [DATA_W-1:0]  wdata_i,
   output logic [DATA_W-1:0]  rdata_o
);

   logic [DATA_W-1:0] mem [BUF_WORDS];

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem[addr_i] <= wdata_i;
         end else begin
            rdata_o <= mem[addr_i];
         end
      end
   end

endmodule

// File: src/buffer_arbiter.sv
/*
 * Trace buffer arbiter
 * Fixed priority for the single SRAM port, engine first, then host readout
 */
`timescale 1ns/1ps

module buffer_arbiter import snoop_pkg::*; (
   input  logic               eng_req_i,
   input  logic [ADDR_W-1:0]  eng_addr_i,
   input  logic [DATA_W-1:0]  eng_wdata_i,
   input  logic               rdp_req_i,
   input  logic [ADDR_W-1:0]  rdp_addr_i,
   output logic               eng_gnt_o,
   output logic               rdp_gnt_o,
   output logic               mem_en_o,
   output logic               mem_we_o,
   output logic [WORD_AW-1:0] mem_addr_o,
   output logic [DATA_W-1:0]  mem_wdata_o
);

   logic [ADDR_W-1:0] sel_addr;

   // Engine wins whenever it asks
   assign eng_gnt_o = eng_req_i;
   assign rdp_gnt_o = rdp_req_i & ~eng_req_i;

   always_comb begin
      mem_en_o = 1'b0;
      mem_we_o = 1'b0;
      sel_addr = '0;
      if (eng_req_i) begin
         mem_en_o = 1'b1;
         mem_we_o = 1'b1;
         sel_addr = eng_addr_i;
      end else if (rdp_req_i) begin
         mem_en_o = 1'b1;
         sel_addr = rdp_addr_i;
      end
   end

   // Byte address to word address
   assign mem_addr_o  = sel_addr[ADDR_W-1:2];
   // Only the engine ever writes
   assign mem_wdata_o = eng_wdata_i;

endmodule

// File: src/trace_engine.sv
/*
 * Trace snooping engine
 * Captures a trace record on a strobe and writes it word by word into the
 * circular buffer, keeping the write, first-valid and last-valid pointers
 */
`timescale 1ns/1ps

module trace_engine import snoop_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              trace_valid_i,
   input  logic              snoop_en_i,
   input  mode_e             mode_i,
   input  logic              cnt_rst_i,
   input  logic [DATA_W-1:0] pc_src_l_i,
   input  logic [DATA_W-1:0] pc_src_h_i,
   input  logic [DATA_W-1:0] pc_dst_l_i,
   input  logic [DATA_W-1:0] pc_dst_h_i,
   input  logic [DATA_W-1:0] metadata_i,
   input  logic [DATA_W-1:0] opcode_i,
   input  logic              gnt_i,
   output logic              req_o,
   output logic [ADDR_W-1:0] addr_o,
   output logic [DATA_W-1:0] wdata_o,
   output logic [ADDR_W-1:0] cnt_o,
   output logic [ADDR_W-1:0] first_valid_o,
   output logic [ADDR_W-1:0] last_valid_o,
   output logic [DATA_W-1:0] drop_cnt_o
);

   trace_rec_u        rec_d, rec_q;
   logic [ADDR_W-1:0] start_q;
   logic              busy_q;
   logic              wrapped_q;
   logic [IDX_W-1:0]  word_idx_q;
   logic [IDX_W-1:0]  last_idx_q;

   logic              accept;
   logic              drop;
   logic [ADDR_W-1:0] incr;
   logic [ADDR_W-1:0] limit;
   logic [ADDR_W:0]   cnt_sum;
   logic              overflow;
   logic [ADDR_W-1:0] cnt_new;
   logic              wrap_next;

   assign accept = trace_valid_i & snoop_en_i & ~busy_q;
   assign drop   = trace_valid_i & snoop_en_i & busy_q;

   // Pick the view of the record that matches the current mode
   always_comb begin
      rec_d = '0;
      if (mode_i == MODE_INSTR) begin
         rec_d.instr.opcode = opcode_i;
      end else begin
         rec_d.addr.pc_src_l = pc_src_l_i;
         rec_d.addr.pc_src_h = pc_src_h_i;
         rec_d.addr.pc_dst_l = pc_dst_l_i;
         rec_d.addr.pc_dst_h = pc_dst_h_i;
         rec_d.addr.metadata = metadata_i;
      end
   end

   assign incr  = (mode_i == MODE_INSTR) ? INSTR_MODE_INCR : ADDR_MODE_INCR;
   assign limit = (mode_i == MODE_INSTR) ? INSTR_MODE_MAX : ADDR_MODE_MAX;

   // One extra bit, since 1020 + 4 does not fit in ADDR_W
   assign cnt_sum   = {1'b0, cnt_o} + {1'b0, incr};
   assign overflow  = cnt_sum > {1'b0, limit};
   assign cnt_new   = overflow ? '0 : cnt_sum[ADDR_W-1:0];
   assign wrap_next = wrapped_q | overflow;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         busy_q        <= 1'b0;
         word_idx_q    <= '0;
         last_idx_q    <= '0;
         wrapped_q     <= 1'b0;
         cnt_o         <= '0;
         first_valid_o <= '0;
         last_valid_o  <= '0;
         drop_cnt_o    <= '0;
      end else if (cnt_rst_i) begin
         // Also abandons a record that is still being written
         busy_q        <= 1'b0;
         word_idx_q    <= '0;
         wrapped_q     <= 1'b0;
         cnt_o         <= '0;
         first_valid_o <= '0;
         last_valid_o  <= '0;
         drop_cnt_o    <= '0;
      end else begin
         if (accept) begin
            busy_q       <= 1'b1;
            word_idx_q   <= '0;
            last_idx_q   <= (mode_i == MODE_INSTR) ? '0 : IDX_W'(REC_WORDS - 1);
            cnt_o        <= cnt_new;
            last_valid_o <= cnt_o;
            wrapped_q    <= wrap_next;
            // Once wrapped, the next slot to be overwritten is the oldest record
            if (wrap_next) begin
               first_valid_o <= cnt_new;
            end
         end else if (busy_q && gnt_i) begin
            // Engine has priority, so the grant is always there
            if (word_idx_q == last_idx_q) begin
               busy_q <= 1'b0;
            end else begin
               word_idx_q <= word_idx_q + 1'b1;
            end
         end
         if (drop) begin
            drop_cnt_o <= drop_cnt_o + 1'b1;
         end
      end
   end

   // Record payload and its start address
   always_ff @(posedge clk_i) begin
      if (accept) begin
         rec_q   <= rec_d;
         start_q <= cnt_o;
      end
   end

   assign req_o   = busy_q;
   assign addr_o  = start_q + (ADDR_W'(word_idx_q) << 2);
   assign wdata_o = rec_q[DATA_W*word_idx_q +: DATA_W];

endmodule

// File: src/snoop_pkg.sv
/*
 * Trace snooper shared definitions
 * Buffer geometry, per-mode pointer steps and limits, and the trace record type
 */
package snoop_pkg;

   localparam int unsigned ADDR_W          = 10;
   localparam int unsigned DATA_W          = 32;
   localparam int unsigned TRACE_BUF_BYTES = 1024;
   localparam int unsigned BUF_WORDS       = TRACE_BUF_BYTES / 4;
   localparam int unsigned WORD_AW         = ADDR_W - 2;

   // Words per address-mode record and the width of a word index into it
   localparam int unsigned REC_WORDS = 5;
   localparam int unsigned IDX_W     = $clog2(REC_WORDS);

   // Pointer steps in bytes
   localparam logic [ADDR_W-1:0] ADDR_MODE_INCR  = 10'd20;
   localparam logic [ADDR_W-1:0] INSTR_MODE_INCR = 10'd4;

   // Highest record start that still fits in the buffer
   localparam logic [ADDR_W-1:0] ADDR_MODE_MAX  = 10'd1004;
   localparam logic [ADDR_W-1:0] INSTR_MODE_MAX = 10'd1020;

   typedef enum logic {
      MODE_ADDRESS = 1'b0,
      MODE_INSTR   = 1'b1
   } mode_e;

   // One trace record, five words wide; word 0 sits in the low slice
   typedef union packed {
      struct packed {
         logic [DATA_W-1:0] metadata;
         logic [DATA_W-1:0] pc_dst_h;
         logic [DATA_W-1:0] pc_dst_l;
         logic [DATA_W-1:0] pc_src_h;
         logic [DATA_W-1:0] pc_src_l;
      } addr;
      struct packed {
         logic [REC_WORDS-2:0][DATA_W-1:0] pad;
         logic [DATA_W-1:0]                opcode;
      } instr;
   } trace_rec_u;

endpackage
